//--- bench/fetch_cases.txt
# Fields are hex: cmd argA argB
# C word tryLoad | L word expDrop | P base count | R fetches extraLoads | F full empty
# Reset then clear, four zero words from byte address 0
C 0 0
F 0 1
R 4 0
# One word per predecode class, BEQ BNE J JAL JR JALR ADD ADDI ANDI
C 0 0
L 10220003 0
L 1441fffe 0
L 08000010 0
L 0c000020 0
L 03e00008 0
L 0040f809 0
L 00851020 0
L 2084000a 0
L 30420008 0
F 0 0
R 2 0
# Random loads while fetching, the PC holds on each write
R 0e 3
# Fill all 512 words, a write while full is dropped
C 0 0
P 8c000000 200
F 1 0
L deadbeef 1
F 1 0
R 8 0
C 0 0
F 0 1
# Strobe during the sweep is dropped, memory stays zero
C 2468ace0 1
F 0 1
R 2 0

//--- instrFetch.f
verilog/instrFetchPkg.sv
verilog/instructionMemory.sv
verilog/memArbiter.sv
verilog/programLoader.sv
verilog/fetchUnit.sv
verilog/instrFetchTop.sv
bench/instrFetchTb.sv

//--- Makefile
# Verilator build and run for the instruction fetch testbench

VERILATOR ?= verilator
TOP       ?= instrFetchTb
FILELIST  ?= instrFetch.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJDIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "SIMULATION FAILED" $(LOG); then echo "Test failed, see $(LOG)"; exit 1; fi; \
	if ! grep -q "SIMULATION PASSED" $(LOG); then echo "No result line in $(LOG)"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "Simulator exit status $$status"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- bench/instrFetchTb.sv
`default_nettype none

module instrFetchTb;

    timeunit 1ns;
    timeprecision 1ps;

    logic        i_clock;
    logic        i_rstN;
    logic        i_loadWrite;
    logic [31:0] i_loadWord;
    logic        i_clear;
    logic        i_run;
    logic        o_fullMem;
    logic        o_emptyMem;
    logic        o_clearBusy;
    logic        o_loadDrop;
    logic        o_instValid;
    logic [31:0] o_instruction;
    logic [31:0] o_pc;
    logic        o_branch;
    logic        o_jump;

    logic [31:0] model [0:511];             // Expected memory contents
    int          loadPtr = 0;               // Model write pointer
    int          expPc = 0;                 // Word address of the next model read
    logic [31:0] pendWord [$];              // Reads issued and not yet returned
    int          pendPc [$];
    logic [7:0]  cmdQ [$];                  // Parsed cases file
    logic [31:0] aQ [$];
    logic [31:0] bQ [$];
    int          mismatches = 0;
    int          otherErrors = 0;
    int          cycles = 0;
    int          cycleLimit = 0;
    integer      seed = 32'hde80f294;

    instrFetchTop instrFetchTop_inst (.*);

    initial begin
        i_clock = 1'b0;
        forever #5 i_clock = ~i_clock;
    end

    task automatic compareValue(input string name, input logic [31:0] expVal,
                                input logic [31:0] actVal);
        assert (actVal === expVal) else begin
            mismatches++;
            $display("MISMATCH %s expected %08h got %08h at %0t", name, expVal, actVal, $time);
        end
    endtask

    // Flags as {branch, jump} from the MIPS opcode and function tables
    function automatic logic [1:0] expectedFlags(input logic [31:0] w);
        logic [1:0] flags;
        case (w[31:26])
            6'd4, 6'd5: flags = 2'b10;                   // BEQ and BNE
            6'd2, 6'd3: flags = 2'b01;                   // J and JAL
            6'd0:       flags = {1'b0, (w[5:0] == 6'd8) || (w[5:0] == 6'd9)};   // JR or JALR
            default:    flags = 2'b00;
        endcase
        return flags;
    endfunction

    // Check each fetched word at the falling edge
    always @(negedge i_clock) begin
        logic [1:0] flags;
        if (o_instValid) begin
            assert (pendPc.size() != 0) else begin
                otherErrors++;
                $display("Instruction valid with no read outstanding at %0t", $time);
            end
            if (pendPc.size() != 0) begin
                flags = expectedFlags(pendWord[0]);
                compareValue("o_instruction", pendWord[0], o_instruction);
                compareValue("o_pc", pendPc[0] * 4, o_pc);   // Byte address
                compareValue("o_branch", flags[1], o_branch);
                compareValue("o_jump", flags[0], o_jump);
                void'(pendWord.pop_front());
                void'(pendPc.pop_front());
            end
        end
    end

    initial begin
        wait (cycleLimit > 0);
        while (cycles < cycleLimit) begin
            @(posedge i_clock);
            cycles++;
        end
        $display("Timeout after %0d cycles, the run did not complete", cycleLimit);
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic clearMemory(input logic [31:0] word, input logic tryLoad);
        int busy;
        busy = 0;
        @(negedge i_clock);
        i_run   = 1'b0;
        i_clear = 1'b1;
        @(negedge i_clock);
        i_clear = 1'b0;
        while (o_clearBusy) begin
            busy++;
            i_loadWrite = tryLoad && (busy == 10);        // One strobe mid-sweep
            i_loadWord  = word;
            if (tryLoad && busy == 11) begin
                compareValue("o_loadDrop", 1, o_loadDrop);
            end
            @(negedge i_clock);
        end
        compareValue("o_clearBusy cycles", 512, busy);
        for (int a = 0; a < 512; a++) model[a] = '0;
        loadPtr = 0;
        expPc   = 0;                                       // Clear also resets the PC
    endtask

    task automatic loadOne(input logic [31:0] word, input logic expDrop);
        @(negedge i_clock);
        i_loadWrite = 1'b1;
        i_loadWord  = word;
        @(negedge i_clock);
        i_loadWrite = 1'b0;
        compareValue("o_loadDrop", expDrop, o_loadDrop);
        if (!expDrop) begin
            model[loadPtr % 512] = word;
            loadPtr++;
        end
    endtask

    // Fetch count words with extra random loads in the first 2*extra slots
    task automatic runFetch(input int count, input int extra);
        int          issued;
        int          loadsLeft;
        int          slot;
        logic [31:0] coin;
        logic        doLoad;
        issued    = 0;
        loadsLeft = extra;
        slot      = 0;
        while (issued < count || loadsLeft > 0) begin
            @(negedge i_clock);
            compareValue("o_loadDrop", 0, o_loadDrop);
            coin   = $random(seed);
            doLoad = (loadsLeft > 0)
                  && (coin[0] || (issued >= count) || (slot + loadsLeft >= 2 * extra));
            slot++;
            i_run       = 1'b1;
            i_loadWrite = doLoad;                          // Write wins over the fetch
            if (doLoad) begin
                i_loadWord           = $random(seed);
                model[loadPtr % 512] = i_loadWord;
                loadPtr++;
                loadsLeft--;
            end else begin
                pendWord.push_back(model[expPc]);
                pendPc.push_back(expPc);
                expPc = (expPc + 1) % 512;
                issued++;
            end
        end
        @(negedge i_clock);
        i_run       = 1'b0;
        i_loadWrite = 1'b0;
        compareValue("o_loadDrop", 0, o_loadDrop);
        while (pendPc.size() != 0) @(negedge i_clock);     // Drain reads in flight
    endtask

    initial begin
        int                fd;
        int                code;
        int                budget;
        logic [63:0]       cmdStr;
        logic [8*128-1:0]  restLine;
        logic [31:0]       argA;
        logic [31:0]       argB;
        i_rstN      = 1'b0;
        i_clear     = 1'b0;
        i_loadWrite = 1'b0;
        i_loadWord  = '0;
        i_run       = 1'b0;
        budget      = 0;
        fd = $fopen("bench/fetch_cases.txt", "r");
        assert (fd != 0) else begin
            otherErrors++;
            $display("Could not open bench/fetch_cases.txt");
        end
        while (fd != 0 && $fscanf(fd, "%s", cmdStr) == 1) begin
            if (cmdStr == "#") begin
                code = $fgets(restLine, fd);               // Skip comment text
            end else begin
                code = $fscanf(fd, "%h %h", argA, argB);
                cmdQ.push_back(cmdStr[7:0]);
                aQ.push_back(argA);
                bQ.push_back(argB);
                case (cmdStr[7:0])
                    "C": budget += 600;
                    "L": budget += 4;
                    "P": budget += 4 * argB;               // Each filled word is a load
                    "R": budget += 3 * argA + 4 * argB;
                    default: budget += 0;
                endcase
            end
        end
        if (fd != 0) $fclose(fd);
        cycleLimit = budget + 200;
        repeat (5) @(posedge i_clock);
        @(negedge i_clock);
        i_rstN = 1'b1;
        compareValue("o_emptyMem", 1, o_emptyMem);        // Reset state
        compareValue("o_fullMem", 0, o_fullMem);
        compareValue("o_instValid", 0, o_instValid);
        compareValue("o_clearBusy", 0, o_clearBusy);
        compareValue("o_loadDrop", 0, o_loadDrop);
        foreach (cmdQ[i]) begin
            argA = aQ[i];
            argB = bQ[i];
            case (cmdQ[i])
                "C": clearMemory(argA, argB[0]);
                "L": loadOne(argA, argB[0]);
                "P": for (int n = 0; n < argB; n++) loadOne(argA ^ (loadPtr * 32'h0001_0001), 0);
                "R": runFetch(argA, argB);
                "F": begin
                    compareValue("o_fullMem", argA, o_fullMem);
                    compareValue("o_emptyMem", argB, o_emptyMem);
                end
                default: assert (0) else begin
                    otherErrors++;
                    $display("Unknown command %c in cases file", cmdQ[i]);
                end
            endcase
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatches, otherErrors);
        if (mismatches == 0 && otherErrors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/instrFetchTop.sv
`default_nettype none

module instrFetchTop (
    input  wire                               i_clock,
    input  wire                               i_rstN,
    // Debug loader
    input  wire                               i_loadWrite,
    input  wire [instrFetchPkg::WORD_W-1:0]   i_loadWord,
    input  wire                               i_clear,
    output logic                              o_fullMem,
    output logic                              o_emptyMem,
    output logic                              o_clearBusy,
    output logic                              o_loadDrop,
    // Fetch
    input  wire                               i_run,
    output logic                              o_instValid,
    output logic [instrFetchPkg::WORD_W-1:0]  o_instruction,
    output logic [instrFetchPkg::WORD_W-1:0]  o_pc,
    output logic                              o_branch,
    output logic                              o_jump
);

    // Loader to arbiter
    logic                             loadReq;
    logic [instrFetchPkg::ADDR_W-1:0] loadAddr;
    logic [instrFetchPkg::WORD_W-1:0] loadData;
    logic                             loadGnt;
    // Fetch to arbiter
    logic                             fetchReq;
    logic [instrFetchPkg::ADDR_W-1:0] fetchAddr;
    logic                             fetchGnt;
    logic [instrFetchPkg::WORD_W-1:0] fetchRdata;
    // Arbiter to memory
    logic                             memEn;
    logic                             memWe;
    logic [instrFetchPkg::ADDR_W-1:0] memAddr;
    logic [instrFetchPkg::WORD_W-1:0] memWdata;
    logic [instrFetchPkg::WORD_W-1:0] memRdata;

    programLoader programLoader_inst (
        .i_clock     (i_clock),
        .i_rstN      (i_rstN),
        .i_clear     (i_clear),
        .i_loadWrite (i_loadWrite),
        .i_loadWord  (i_loadWord),
        .o_loadReq   (loadReq),
        .o_loadAddr  (loadAddr),
        .o_loadData  (loadData),
        .i_loadGnt   (loadGnt),
        .o_fullMem   (o_fullMem),
        .o_emptyMem  (o_emptyMem),
        .o_clearBusy (o_clearBusy),
        .o_loadDrop  (o_loadDrop)
    );

    fetchUnit fetchUnit_inst (
        .i_clock       (i_clock),
        .i_rstN        (i_rstN),
        .i_run         (i_run),
        .i_clear       (i_clear),
        .i_clearBusy   (o_clearBusy),    // Sweep blocks fetching
        .o_fetchReq    (fetchReq),
        .o_fetchAddr   (fetchAddr),
        .i_fetchGnt    (fetchGnt),
        .i_fetchRdata  (fetchRdata),
        .o_instValid   (o_instValid),
        .o_instruction (o_instruction),
        .o_pc          (o_pc),
        .o_branch      (o_branch),
        .o_jump        (o_jump)
    );

    memArbiter memArbiter_inst (
        .i_clock      (i_clock),
        .i_rstN       (i_rstN),
        .i_loadReq    (loadReq),
        .i_loadAddr   (loadAddr),
        .i_loadData   (loadData),
        .o_loadGnt    (loadGnt),
        .i_fetchReq   (fetchReq),
        .i_fetchAddr  (fetchAddr),
        .o_fetchGnt   (fetchGnt),
        .o_fetchRdata (fetchRdata),
        .o_memEn      (memEn),
        .o_memWe      (memWe),
        .o_memAddr    (memAddr),
        .o_memWdata   (memWdata),
        .i_memRdata   (memRdata)
    );

    instructionMemory instructionMemory_inst (
        .i_clock (i_clock),
        .i_en    (memEn),
        .i_we    (memWe),
        .i_addr  (memAddr),
        .i_wdata (memWdata),
        .o_rdata (memRdata)
    );

endmodule

`default_nettype wire

//--- verilog/fetchUnit.sv
`default_nettype none

module fetchUnit (
    input  wire                               i_clock,
    input  wire                               i_rstN,
    input  wire                               i_run,         // Level, fetch while high
    input  wire                               i_clear,       // Sends PC back to 0
    input  wire                               i_clearBusy,   // Sweep owns the memory
    output logic                              o_fetchReq,
    output logic [instrFetchPkg::ADDR_W-1:0]  o_fetchAddr,
    input  wire                               i_fetchGnt,
    input  wire [instrFetchPkg::WORD_W-1:0]   i_fetchRdata,
    output logic                              o_instValid,
    output logic [instrFetchPkg::WORD_W-1:0]  o_instruction,
    output logic [instrFetchPkg::WORD_W-1:0]  o_pc,          // Byte address
    output logic                              o_branch,      // BEQ or BNE
    output logic                              o_jump         // J, JAL, JR or JALR
);

    localparam int PAD_W = instrFetchPkg::WORD_W - instrFetchPkg::ADDR_W - 2;

    logic [instrFetchPkg::ADDR_W-1:0] pc;         // Word address of next read
    logic                             rdValid;    // RAM output holds a fetched word
    logic [instrFetchPkg::ADDR_W-1:0] rdAddr;     // Its word address
    logic [instrFetchPkg::OP_W-1:0]   opcode;
    logic [instrFetchPkg::FN_W-1:0]   funct;
    logic                             isBranch;
    logic                             isJump;

    // Ask for the port whenever running and memory is free
    assign o_fetchReq  = i_run & ~i_clearBusy & ~i_clear;
    assign o_fetchAddr = pc;

    // Predecode on the word coming out of the RAM
    assign opcode = i_fetchRdata[instrFetchPkg::WORD_W-1 -: instrFetchPkg::OP_W];
    assign funct  = i_fetchRdata[instrFetchPkg::FN_W-1:0];

    assign isBranch = (opcode == instrFetchPkg::OP_BEQ) || (opcode == instrFetchPkg::OP_BNE);
    assign isJump   = (opcode == instrFetchPkg::OP_J)
                   || (opcode == instrFetchPkg::OP_JAL)
                   || ((opcode == instrFetchPkg::OP_RTYPE)
                       && ((funct == instrFetchPkg::FN_JR)
                           || (funct == instrFetchPkg::FN_JALR)));

    // PC only moves on a grant, so a stall repeats nothing
    always_ff @(posedge i_clock or negedge i_rstN) begin
        if (!i_rstN) begin
            pc <= '0;
        end else if (i_clear) begin
            pc <= '0;
        end else if (i_fetchGnt) begin
            pc <= pc + 1'b1;
        end
    end

    // Valid pipeline, RAM stage then predecode stage
    always_ff @(posedge i_clock or negedge i_rstN) begin
        if (!i_rstN) begin
            rdValid     <= 1'b0;
            o_instValid <= 1'b0;
            o_branch    <= 1'b0;
            o_jump      <= 1'b0;
        end else begin
            rdValid     <= i_fetchGnt;                 // Read issued this cycle
            o_instValid <= rdValid;
            o_branch    <= rdValid & isBranch;         // Flags stay low between words
            o_jump      <= rdValid & isJump;
        end
    end

    // Address travels alongside the read
    always_ff @(posedge i_clock) begin
        if (i_fetchGnt) begin
            rdAddr <= pc;
        end
    end

    // Output payload
    always_ff @(posedge i_clock) begin
        if (rdValid) begin
            o_instruction <= i_fetchRdata;
            o_pc          <= {{PAD_W{1'b0}}, rdAddr, 2'b00};   // Word to byte address
        end
    end

    // The predecode classes are disjoint
    flagsExclusive: assert property (@(posedge i_clock) disable iff (!i_rstN)
        !(o_branch && o_jump))
        else $error("fetchUnit: branch and jump both high");

endmodule

`default_nettype wire

//--- verilog/programLoader.sv
`default_nettype none

module programLoader (
    input  wire                               i_clock,
    input  wire                               i_rstN,
    input  wire                               i_clear,      // One-cycle pulse, starts sweep
    input  wire                               i_loadWrite,  // Strobe, one word
    input  wire [instrFetchPkg::WORD_W-1:0]   i_loadWord,
    output logic                              o_loadReq,
    output logic [instrFetchPkg::ADDR_W-1:0]  o_loadAddr,
    output logic [instrFetchPkg::WORD_W-1:0]  o_loadData,
    input  wire                               i_loadGnt,
    output logic                              o_fullMem,
    output logic                              o_emptyMem,
    output logic                              o_clearBusy,
    output logic                              o_loadDrop    // Rejected word, one pulse
);

    logic [instrFetchPkg::CNT_W-1:0]  count;      // Words written so far, also write pointer
    logic [instrFetchPkg::ADDR_W-1:0] sweepAddr;  // Zero-fill position
    logic                             sweepOn;
    logic                             bufValid;   // Word waiting for a grant
    logic [instrFetchPkg::WORD_W-1:0] bufWord;
    logic                             accept;     // Strobe taken this cycle
    logic                             sweepLast;

    assign o_fullMem   = (count == instrFetchPkg::CNT_FULL);
    assign o_emptyMem  = (count == '0);
    assign o_clearBusy = sweepOn;

    // Strobe is rejected when full, sweeping, clearing or buffer busy
    assign accept = i_loadWrite & ~o_fullMem & ~sweepOn & ~i_clear & ~bufValid;

    assign sweepLast = sweepOn & (sweepAddr == instrFetchPkg::ADDR_LAST);

    // Request is raised in the same cycle as the strobe
    assign o_loadReq  = sweepOn | bufValid | accept;
    assign o_loadAddr = sweepOn ? sweepAddr : count[instrFetchPkg::ADDR_W-1:0];
    assign o_loadData = sweepOn ? '0 : (bufValid ? bufWord : i_loadWord);

    always_ff @(posedge i_clock or negedge i_rstN) begin
        if (!i_rstN) begin
            count      <= '0;
            sweepAddr  <= '0;
            sweepOn    <= 1'b0;
            bufValid   <= 1'b0;
            o_loadDrop <= 1'b0;
        end else begin
            o_loadDrop <= i_loadWrite & ~accept;       // Flag any lost word
            if (i_clear) begin
                sweepOn   <= 1'b1;                     // Restart sweep from word 0
                sweepAddr <= '0;
                bufValid  <= 1'b0;
            end else if (sweepOn) begin
                if (i_loadGnt) begin
                    sweepAddr <= sweepAddr + 1'b1;
                    if (sweepLast) begin
                        sweepOn <= 1'b0;
                        count   <= '0;                 // Pointer back to start
                    end
                end
            end else if (o_loadReq && i_loadGnt) begin
                count    <= count + 1'b1;              // Word landed, advance
                bufValid <= 1'b0;
            end else if (accept) begin
                bufValid <= 1'b1;                      // Hold until granted
            end
        end
    end

    // Buffer payload
    always_ff @(posedge i_clock) begin
        if (accept && !i_loadGnt) begin
            bufWord <= i_loadWord;
        end
    end

    countInRange: assert property (@(posedge i_clock) disable iff (!i_rstN)
        count <= instrFetchPkg::CNT_FULL)
        else $error("programLoader: count past memory depth");

endmodule

`default_nettype wire

//--- verilog/memArbiter.sv
`default_nettype none

module memArbiter (
    input  wire                               i_clock,
    input  wire                               i_rstN,
    // Loader side, always a write
    input  wire                               i_loadReq,
    input  wire [instrFetchPkg::ADDR_W-1:0]   i_loadAddr,
    input  wire [instrFetchPkg::WORD_W-1:0]   i_loadData,
    output logic                              o_loadGnt,
    // Fetch side, always a read
    input  wire                               i_fetchReq,
    input  wire [instrFetchPkg::ADDR_W-1:0]   i_fetchAddr,
    output logic                              o_fetchGnt,
    output logic [instrFetchPkg::WORD_W-1:0]  o_fetchRdata,
    // Memory port
    output logic                              o_memEn,
    output logic                              o_memWe,
    output logic [instrFetchPkg::ADDR_W-1:0]  o_memAddr,
    output logic [instrFetchPkg::WORD_W-1:0]  o_memWdata,
    input  wire [instrFetchPkg::WORD_W-1:0]   i_memRdata
);

    // Fixed priority, loader first
    assign o_loadGnt  = i_loadReq;
    assign o_fetchGnt = i_fetchReq & ~i_loadReq;    // Fetch only on an idle loader

    // Steer the winner onto the port
    assign o_memEn    = o_loadGnt | o_fetchGnt;
    assign o_memWe    = o_loadGnt;                  // Loader owns every write
    assign o_memAddr  = o_loadGnt ? i_loadAddr : i_fetchAddr;
    assign o_memWdata = o_loadGnt ? i_loadData : '0;

    // Only the fetch unit ever reads
    assign o_fetchRdata = i_memRdata;

    // Never two owners of the port
    gntOneHot: assert property (@(posedge i_clock) disable iff (!i_rstN)
        $onehot0({o_loadGnt, o_fetchGnt}))
        else $error("memArbiter: both grants high");

    // A grant always answers a live request
    gntHasReq: assert property (@(posedge i_clock) disable iff (!i_rstN)
        (o_loadGnt |-> i_loadReq) and (o_fetchGnt |-> i_fetchReq))
        else $error("memArbiter: grant without request");

endmodule

`default_nettype wire

//--- verilog/instructionMemory.sv
`default_nettype none

module instructionMemory (
    input  wire                               i_clock,
    input  wire                               i_en,      // Port enable
    input  wire                               i_we,      // Write when high, else read
    input  wire [instrFetchPkg::ADDR_W-1:0]   i_addr,    // Word address
    input  wire [instrFetchPkg::WORD_W-1:0]   i_wdata,
    output logic [instrFetchPkg::WORD_W-1:0]  o_rdata    // Valid one cycle after a read
);

    // Storage array, contents undefined until the loader sweeps it
    logic [instrFetchPkg::WORD_W-1:0] mem [0:instrFetchPkg::MEM_DEPTH-1];

    // Write path
    always_ff @(posedge i_clock) begin
        if (i_en && i_we) begin
            mem[i_addr] <= i_wdata;              // Takes effect at this edge
        end
    end

    // Registered read, a write leaves o_rdata alone
    always_ff @(posedge i_clock) begin
        if (i_en && !i_we) begin
            o_rdata <= mem[i_addr];
        end
    end

    // An enabled access must point at a real word
    addrKnown: assert property (@(posedge i_clock) i_en |-> !$isunknown(i_addr))
        else $error("instructionMemory: unknown address on enabled access");

endmodule

`default_nettype wire

//--- verilog/instrFetchPkg.sv
`default_nettype none

package instrFetchPkg;

    // Memory geometry
    localparam int WORD_W    = 32;          // Instruction word width
    localparam int MEM_DEPTH = 512;         // Words in the instruction memory
    localparam int ADDR_W    = 9;           // Word address, log2 of MEM_DEPTH
    localparam int CNT_W     = 10;          // Load count, one bit wider so 512 fits

    // Count value that means every word is written
    localparam logic [CNT_W-1:0]  CNT_FULL  = CNT_W'(MEM_DEPTH);
    // Last word address touched by the zero-fill sweep
    localparam logic [ADDR_W-1:0] ADDR_LAST = ADDR_W'(MEM_DEPTH - 1);

    // Instruction fields
    localparam int OP_W = 6;                // Opcode sits in bits 31:26
    localparam int FN_W = 6;                // Function code sits in bits 5:0

    // Opcodes that make a word a branch
    localparam logic [OP_W-1:0] OP_BEQ   = 6'd4;
    localparam logic [OP_W-1:0] OP_BNE   = 6'd5;

    // Opcodes that make a word a jump
    localparam logic [OP_W-1:0] OP_J     = 6'd2;
    localparam logic [OP_W-1:0] OP_JAL   = 6'd3;

    // Register format, the function code selects the operation
    localparam logic [OP_W-1:0] OP_RTYPE = 6'd0;

    // R-type function codes that are jumps through a register
    localparam logic [FN_W-1:0] FN_JR    = 6'd8;
    localparam logic [FN_W-1:0] FN_JALR  = 6'd9;

endpackage

`default_nettype wire
